//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths.
`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_NUM_REGS    32

// data memory depth in words and word address width.
`define CPU_DMEM_WORDS  256
`define CPU_DMEM_AW     8

`endif

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // memory access kind carried with each instruction.
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // access size as encoded in funct3[1:0].
    typedef enum logic [1:0] {
        MW_BYTE = 2'd0,
        MW_HALF = 2'd1,
        MW_WORD = 2'd2
    } mem_width_e;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package pipe_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // one write strobe per byte lane.
    typedef logic [`CPU_XLEN/8-1:0] byte_en_t;

endpackage

`default_nettype wire

//--- src/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module data_mem (
    input  logic                     clk,
    input  logic                     re_i,
    input  logic [`CPU_DMEM_AW-1:0]  addr_i,
    input  pipe_pkg::byte_en_t       be_i,
    input  pipe_pkg::word_t          wdata_i,
    output pipe_pkg::word_t          rdata_o
);
    import pipe_pkg::*;

    word_t mem [0:`CPU_DMEM_WORDS-1];

    // byte lane writes.
    always_ff @(posedge clk) begin
        for (int b = 0; b < `CPU_XLEN/8; b++) begin
            if (be_i[b]) begin
                mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // registered read that holds while re_i is low.
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module mem_stage (
    input  pipe_pkg::word_t          op_c_i,
    input  pipe_pkg::word_t          store_data_i,
    input  isa_pkg::mem_op_e         mem_op_i,
    input  isa_pkg::mem_width_e      mem_width_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    output logic [`CPU_DMEM_AW-1:0]  dmem_addr_o,
    output pipe_pkg::byte_en_t       dmem_be_o,
    output pipe_pkg::word_t          dmem_wdata_o,
    output logic                     dmem_re_o,
    output logic                     mtype_o,
    output logic [1:0]               lane_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic     store_ok;
    byte_en_t width_be;

    assign dmem_addr_o = op_c_i[`CPU_DMEM_AW+1:2];
    assign lane_o      = op_c_i[1:0];
    assign mtype_o     = (mem_op_i == MEM_LOAD);

    // read data must stay put while the pipe is stalled.
    assign dmem_re_o = mtype_o && !stall_i;

    // flush kills the store, unless stall holds the stage.
    assign store_ok = (mem_op_i == MEM_STORE) && !(flush_i && !stall_i);

    always_comb begin
        case (mem_width_i)
            MW_BYTE: begin
                width_be     = 4'b0001 << lane_o;
                dmem_wdata_o = word_t'(store_data_i[7:0]) << {lane_o, 3'b000};
            end
            MW_HALF: begin
                width_be     = 4'b0011 << {lane_o[1], 1'b0};
                dmem_wdata_o = word_t'(store_data_i[15:0]) << {lane_o[1], 4'b0000};
            end
            default: begin
                width_be     = 4'b1111;
                dmem_wdata_o = store_data_i;
            end
        endcase
    end

    assign dmem_be_o = store_ok ? width_be : '0;

endmodule

`default_nettype wire

//--- src/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    // from mem.
    input  pipe_pkg::word_t      mem_op_c_i,
    input  pipe_pkg::reg_addr_t  mem_reg_waddr_i,
    input  logic                 mem_reg_we_i,
    input  logic                 mem_mtype_i,
    input  isa_pkg::mem_width_e  mem_mem_width_i,
    input  logic                 mem_load_unsigned_i,
    input  logic [1:0]           mem_lane_i,
    // to wb.
    output pipe_pkg::word_t      memwb_op_c_o,
    output pipe_pkg::reg_addr_t  memwb_reg_waddr_o,
    output logic                 memwb_reg_we_o,
    output logic                 memwb_mtype_o,
    output isa_pkg::mem_width_e  memwb_mem_width_o,
    output logic                 memwb_load_unsigned_o,
    output logic [1:0]           memwb_lane_o,
    // strobes.
    input  logic                 stall_i,
    input  logic                 flush_i
);
    import isa_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memwb_op_c_o          <= '0;
            memwb_reg_waddr_o     <= '0;
            memwb_reg_we_o        <= 1'b0;
            memwb_mtype_o         <= 1'b0;
            memwb_mem_width_o     <= MW_BYTE;
            memwb_load_unsigned_o <= 1'b0;
            memwb_lane_o          <= 2'b00;
        end else if (stall_i) begin
            // stall holds the register and wins over flush.
        end else if (flush_i) begin
            memwb_op_c_o          <= '0;
            memwb_reg_waddr_o     <= '0;
            memwb_reg_we_o        <= 1'b0;
            memwb_mtype_o         <= 1'b0;
            memwb_mem_width_o     <= MW_BYTE;
            memwb_load_unsigned_o <= 1'b0;
            memwb_lane_o          <= 2'b00;
        end else begin
            memwb_op_c_o          <= mem_op_c_i;
            memwb_reg_waddr_o     <= mem_reg_waddr_i;
            memwb_reg_we_o        <= mem_reg_we_i;
            memwb_mtype_o         <= mem_mtype_i;
            memwb_mem_width_o     <= mem_mem_width_i;
            memwb_load_unsigned_o <= mem_load_unsigned_i;
            memwb_lane_o          <= mem_lane_i;
        end
    end

endmodule

`default_nettype wire

//--- src/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module wb_stage (
    input  pipe_pkg::word_t      op_c_i,
    input  pipe_pkg::reg_addr_t  reg_waddr_i,
    input  logic                 reg_we_i,
    input  logic                 mtype_i,
    input  isa_pkg::mem_width_e  mem_width_i,
    input  logic                 load_unsigned_i,
    input  logic [1:0]           lane_i,
    input  pipe_pkg::word_t      dmem_rdata_i,
    output logic                 rf_we_o,
    output pipe_pkg::reg_addr_t  rf_waddr_o,
    output pipe_pkg::word_t      rf_wdata_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        ld_sign;
    word_t       load_val;

    // halfwords are assumed aligned.
    assign ld_byte = dmem_rdata_i[{lane_i, 3'b000} +: 8];
    assign ld_half = lane_i[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];

    always_comb begin
        case (mem_width_i)
            MW_BYTE: begin
                ld_sign  = ld_byte[7] && !load_unsigned_i;
                load_val = {{(`CPU_XLEN-8){ld_sign}}, ld_byte};
            end
            MW_HALF: begin
                ld_sign  = ld_half[15] && !load_unsigned_i;
                load_val = {{(`CPU_XLEN-16){ld_sign}}, ld_half};
            end
            default: begin
                ld_sign  = 1'b0;
                load_val = dmem_rdata_i;
            end
        endcase
    end

    assign rf_wdata_o = mtype_i ? load_val : op_c_i;
    assign rf_waddr_o = reg_waddr_i;

    // x0 is never written.
    assign rf_we_o = reg_we_i && (reg_waddr_i != '0);

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we_i,
    input  pipe_pkg::reg_addr_t  waddr_i,
    input  pipe_pkg::word_t      wdata_i,
    input  pipe_pkg::reg_addr_t  raddr1_i,
    input  pipe_pkg::reg_addr_t  raddr2_i,
    output pipe_pkg::word_t      rdata1_o,
    output pipe_pkg::word_t      rdata2_o
);
    import pipe_pkg::*;

    // x0 has no storage.
    word_t regs [1:`CPU_NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- src/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module mem_wb_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // from execute.
    input  pipe_pkg::word_t      ex_op_c_i,
    input  pipe_pkg::word_t      ex_store_data_i,
    input  pipe_pkg::reg_addr_t  ex_reg_waddr_i,
    input  logic                 ex_reg_we_i,
    input  isa_pkg::mem_op_e     ex_mem_op_i,
    input  isa_pkg::mem_width_e  ex_mem_width_i,
    input  logic                 ex_load_unsigned_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    // decode read ports.
    input  pipe_pkg::reg_addr_t  rs1_addr_i,
    input  pipe_pkg::reg_addr_t  rs2_addr_i,
    output pipe_pkg::word_t      rs1_data_o,
    output pipe_pkg::word_t      rs2_data_o,
    // register file write port.
    output logic                 wb_reg_we_o,
    output pipe_pkg::reg_addr_t  wb_reg_waddr_o,
    output pipe_pkg::word_t      wb_reg_wdata_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`CPU_DMEM_AW-1:0] dmem_addr;
    byte_en_t                dmem_be;
    word_t                   dmem_wdata;
    logic                    dmem_re;
    word_t                   dmem_rdata;
    logic                    mem_mtype;
    logic [1:0]              mem_lane;

    word_t                   memwb_op_c;
    reg_addr_t               memwb_reg_waddr;
    logic                    memwb_reg_we;
    logic                    memwb_mtype;
    mem_width_e              memwb_mem_width;
    logic                    memwb_load_unsigned;
    logic [1:0]              memwb_lane;

    mem_stage u_mem_stage (
        .op_c_i       (ex_op_c_i),
        .store_data_i (ex_store_data_i),
        .mem_op_i     (ex_mem_op_i),
        .mem_width_i  (ex_mem_width_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .dmem_addr_o  (dmem_addr),
        .dmem_be_o    (dmem_be),
        .dmem_wdata_o (dmem_wdata),
        .dmem_re_o    (dmem_re),
        .mtype_o      (mem_mtype),
        .lane_o       (mem_lane)
    );

    data_mem u_data_mem (
        .clk     (clk),
        .re_i    (dmem_re),
        .addr_i  (dmem_addr),
        .be_i    (dmem_be),
        .wdata_i (dmem_wdata),
        .rdata_o (dmem_rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .mem_op_c_i            (ex_op_c_i),
        .mem_reg_waddr_i       (ex_reg_waddr_i),
        .mem_reg_we_i          (ex_reg_we_i),
        .mem_mtype_i           (mem_mtype),
        .mem_mem_width_i       (ex_mem_width_i),
        .mem_load_unsigned_i   (ex_load_unsigned_i),
        .mem_lane_i            (mem_lane),
        .memwb_op_c_o          (memwb_op_c),
        .memwb_reg_waddr_o     (memwb_reg_waddr),
        .memwb_reg_we_o        (memwb_reg_we),
        .memwb_mtype_o         (memwb_mtype),
        .memwb_mem_width_o     (memwb_mem_width),
        .memwb_load_unsigned_o (memwb_load_unsigned),
        .memwb_lane_o          (memwb_lane),
        .stall_i               (stall_i),
        .flush_i               (flush_i)
    );

    wb_stage u_wb_stage (
        .op_c_i          (memwb_op_c),
        .reg_waddr_i     (memwb_reg_waddr),
        .reg_we_i        (memwb_reg_we),
        .mtype_i         (memwb_mtype),
        .mem_width_i     (memwb_mem_width),
        .load_unsigned_i (memwb_load_unsigned),
        .lane_i          (memwb_lane),
        .dmem_rdata_i    (dmem_rdata),
        .rf_we_o         (wb_reg_we_o),
        .rf_waddr_o      (wb_reg_waddr_o),
        .rf_wdata_o      (wb_reg_wdata_o)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (wb_reg_we_o),
        .waddr_i  (wb_reg_waddr_o),
        .wdata_i  (wb_reg_wdata_o),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NRAND = 400;
    // reset, memory fill, register writes, random traffic and drain.
    localparam int LIMIT = 3 * (10 + 16 + 32 + NRAND + 4) + 100;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       stall_i, flush_i, ex_reg_we_i, ex_load_unsigned_i, wb_reg_we_o;
    word_t      ex_op_c_i, ex_store_data_i, rs1_data_o, rs2_data_o, wb_reg_wdata_o;
    reg_addr_t  ex_reg_waddr_i, rs1_addr_i, rs2_addr_i, wb_reg_waddr_o;
    mem_op_e    ex_mem_op_i;
    mem_width_e ex_mem_width_i;

    // reference model state.
    word_t      mem_m [0:15];
    word_t      rf_m [0:31];
    logic       exp_we;
    reg_addr_t  exp_waddr;
    word_t      exp_wdata;
    logic [3:0] widx;
    logic [1:0] wlane;
    int         port_errs = 0;
    int         read_errs = 0;
    int         cycles = 0;
    integer     seed = 72;

    mem_wb_top DUT (.*);

    always #2 clk = ~clk;

    assign widx  = ex_op_c_i[5:2];
    assign wlane = ex_op_c_i[1:0];

    // lane extraction and extension of a loaded word.
    function automatic word_t load_value(word_t w, logic [1:0] lane, mem_width_e width,
                                         logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{lane, 3'b000} +: 8];
        h = w[{lane[1], 4'b0000} +: 16];
        case (width)
            MW_BYTE: return uns ? {24'b0, b} : {{24{b[7]}}, b};
            MW_HALF: return uns ? {16'b0, h} : {{16{h[15]}}, h};
            default: return w;
        endcase
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_we    <= 1'b0;
            exp_waddr <= '0;
            exp_wdata <= '0;
            for (int i = 0; i < 32; i++) begin
                rf_m[i] <= '0;
            end
        end else begin
            if (exp_we) begin
                rf_m[exp_waddr] <= exp_wdata;
            end
            // a store lands unless flushed without stall.
            if (ex_mem_op_i == MEM_STORE && !(flush_i && !stall_i)) begin
                case (ex_mem_width_i)
                    MW_BYTE: mem_m[widx][{wlane, 3'b000} +: 8] = ex_store_data_i[7:0];
                    MW_HALF: mem_m[widx][{wlane[1], 4'b0000} +: 16] = ex_store_data_i[15:0];
                    default: mem_m[widx] = ex_store_data_i;
                endcase
            end
            if (!stall_i) begin
                exp_we    <= ex_reg_we_i && (ex_reg_waddr_i != '0) && !flush_i;
                exp_waddr <= flush_i ? '0 : ex_reg_waddr_i;
                if (flush_i) begin
                    exp_wdata <= '0;
                end else if (ex_mem_op_i == MEM_LOAD) begin
                    exp_wdata <= load_value(mem_m[widx], wlane, ex_mem_width_i,
                                            ex_load_unsigned_i);
                end else begin
                    exp_wdata <= ex_op_c_i;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) wb_reg_we_o == exp_we)
        else begin
            port_errs++;
            $display("error: wb_reg_we_o got %h expected %h",
                     $sampled(wb_reg_we_o), $sampled(exp_we));
        end
    assert property (@(posedge clk) disable iff (!rst_n) wb_reg_waddr_o == exp_waddr)
        else begin
            port_errs++;
            $display("error: wb_reg_waddr_o got %h expected %h",
                     $sampled(wb_reg_waddr_o), $sampled(exp_waddr));
        end
    assert property (@(posedge clk) disable iff (!rst_n) wb_reg_wdata_o == exp_wdata)
        else begin
            port_errs++;
            $display("error: wb_reg_wdata_o got %h expected %h",
                     $sampled(wb_reg_wdata_o), $sampled(exp_wdata));
        end
    assert property (@(posedge clk) disable iff (!rst_n) rs1_data_o == rf_m[rs1_addr_i])
        else begin
            read_errs++;
            $display("error: rs1_data_o got %h expected %h",
                     $sampled(rs1_data_o), $sampled(rf_m[rs1_addr_i]));
        end
    assert property (@(posedge clk) disable iff (!rst_n) rs2_data_o == rf_m[rs2_addr_i])
        else begin
            read_errs++;
            $display("error: rs2_data_o got %h expected %h",
                     $sampled(rs2_data_o), $sampled(rf_m[rs2_addr_i]));
        end

    task automatic present(mem_op_e op, mem_width_e w, word_t opc, word_t sd,
                           reg_addr_t wa, logic we);
        @(posedge clk);
        ex_mem_op_i        <= op;
        ex_mem_width_i     <= w;
        ex_op_c_i          <= opc;
        ex_store_data_i    <= sd;
        ex_reg_waddr_i     <= wa;
        ex_reg_we_i        <= we;
        ex_load_unsigned_i <= 1'b0;
        stall_i            <= 1'b0;
        flush_i            <= 1'b0;
    endtask

    task automatic issue_random();
        logic [31:0] r;
        mem_op_e     op;
        mem_width_e  w;
        logic [1:0]  lane;
        word_t       opc;
        r  = $random(seed);
        op = (r[1:0] == 2'd3) ? MEM_NONE : mem_op_e'(r[1:0]);
        w  = (r[3:2] == 2'd3) ? MW_WORD : mem_width_e'(r[3:2]);
        // halfwords and words stay aligned.
        lane = (w == MW_WORD) ? 2'b00 : (w == MW_HALF) ? {r[5], 1'b0} : r[5:4];
        opc  = (op == MEM_NONE) ? $random(seed) : {26'b0, r[9:6], lane};
        present(op, w, opc, $random(seed), r[22:18], r[16]);
        ex_load_unsigned_i <= r[17];
        stall_i            <= (r[12:10] == 3'd0);
        flush_i            <= (r[15:13] == 3'd0);
        rs1_addr_i         <= r[27:23];
        rs2_addr_i         <= r[31:27];
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_n              = 1'b0;
        stall_i            = 1'b0;
        flush_i            = 1'b0;
        ex_reg_we_i        = 1'b0;
        ex_load_unsigned_i = 1'b0;
        ex_op_c_i          = '0;
        ex_store_data_i    = '0;
        ex_reg_waddr_i     = '0;
        ex_mem_op_i        = MEM_NONE;
        ex_mem_width_i     = MW_WORD;
        rs1_addr_i         = '0;
        rs2_addr_i         = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // fill the address window with known words.
        for (int i = 0; i < 16; i++) begin
            present(MEM_STORE, MW_WORD, word_t'(i * 4), $random(seed), '0, 1'b0);
        end
        // alu writes that rs1 reads back two cycles later.
        for (int i = 0; i < 32; i++) begin
            present(MEM_NONE, MW_WORD, $random(seed), '0, reg_addr_t'(i), 1'b1);
            rs1_addr_i <= reg_addr_t'(i - 2);
            rs2_addr_i <= reg_addr_t'(i - 1);
        end
        for (int n = 0; n < NRAND; n++) begin
            issue_random();
        end
        repeat (4) present(MEM_NONE, MW_WORD, '0, '0, '0, 1'b0);
        @(negedge clk);
        $display("errors: write port %0d, read ports %0d", port_errs, read_errs);
        if (port_errs + read_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/data_mem.sv
src/mem_stage.sv
src/mem_wb_reg.sv
src/wb_stage.sv
src/reg_file.sv
src/mem_wb_top.sv
sim/tb_mem_wb_top.sv

//--- Makefile
TOP := tb_mem_wb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
